/* verilog/pcie_tlp_pkg.sv */
package pcie_tlp_pkg;

    // Fmt[1:0] and Type[4:0] as one 7-bit code
    typedef enum logic [6:0] {
        MRD32 = 7'b000_0000,    // 3DW memory read, no data
        MWR32 = 7'b100_0000     // 3DW memory write with data
    } tlp_fmt_type_e;

    // Dword length field in header word 0
    localparam int TLP_LEN_W = 10;

    // fc_sel code for transmit credits available
    localparam logic [2:0] FC_SEL_TX_AVAIL = 3'd4;

    // One posted data credit covers four dwords
    localparam int FC_CREDIT_BYTES = 16;

endpackage

/* verilog/axi_wr_pkg.sv */
package axi_wr_pkg;

    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // Write response codes used on B
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10          // Bus mastering off
    } axi_resp_e;

endpackage

/* verilog/ob_write_buffer.sv */
`timescale 1ns/1ps

module ob_write_buffer import axi_wr_pkg::*; #(
    parameter ADDR = 32,
    parameter LEN  = 4
) (
    input  logic                  ob_clk,
    input  logic                  reset,

    // AXI write address
    output logic                  aw_ready,
    input  logic                  aw_valid,
    input  logic [ADDR-1:0]       aw_addr,
    input  logic [LEN-1:0]        aw_len,

    // AXI write data
    output logic                  w_ready,
    input  logic                  w_valid,
    input  logic [AXI_DATA_W-1:0] w_data,
    input  logic [AXI_STRB_W-1:0] w_strb,
    input  logic                  w_last,

    // Descriptor to TLP builder
    input  logic                  desc_ready,
    output logic                  desc_valid,
    output logic [ADDR-1:0]       desc_addr,
    output logic [LEN-1:0]        desc_len,
    output logic [AXI_STRB_W-1:0] desc_be_first,
    output logic [AXI_STRB_W-1:0] desc_be_last,

    // Data read port, head slot
    input  logic [LEN-1:0]        rd_index,
    output logic [AXI_DATA_W-1:0] rd_data
);

    localparam int DEPTH = 1 << LEN;    // Words per slot

    typedef enum logic {
        idle,
        data
    } fill_state_e;

    fill_state_e    state;
    logic           up;                 // Low for the first cycle out of reset
    logic           wr_slot;            // Slot being filled
    logic           rd_slot;            // Slot presented to builder
    logic [1:0]     count;              // Complete bursts held
    logic [LEN-1:0] wr_idx;

    logic [AXI_DATA_W-1:0] mem [2*DEPTH];
    logic [ADDR-1:0]       addr_q [2];
    logic [LEN-1:0]        len_q [2];
    logic [AXI_STRB_W-1:0] be_first_q [2];
    logic [AXI_STRB_W-1:0] be_last_q [2];

    logic aw_fire;
    logic w_fire;
    logic push;
    logic pop;

    // No new AW while a burst is still filling
    assign aw_ready = up && (state == idle) && (count != 2'd2);
    assign w_ready  = (state == data);

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign push    = w_fire && w_last;
    assign pop     = desc_valid && desc_ready;

    always_ff @(posedge ob_clk) begin
        if (reset) begin
            up      <= 1'b0;
            state   <= idle;
            wr_slot <= 1'b0;
            rd_slot <= 1'b0;
            count   <= 2'd0;
            wr_idx  <= '0;
        end else begin
            up <= 1'b1;

            case (state)
                idle: begin
                    if (aw_fire) begin
                        state  <= data;
                        wr_idx <= '0;
                    end
                end
                data: begin
                    if (w_fire) begin
                        wr_idx <= wr_idx + 1'b1;
                        if (w_last) begin
                            state   <= idle;
                            wr_slot <= ~wr_slot;    // Next burst to other slot
                        end
                    end
                end
                default: state <= idle;
            endcase

            if (pop) begin
                rd_slot <= ~rd_slot;
            end

            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Burst storage
    always_ff @(posedge ob_clk) begin
        if (aw_fire) begin
            addr_q[wr_slot] <= aw_addr;
            len_q[wr_slot]  <= aw_len;
        end
        if (w_fire) begin
            mem[{wr_slot, wr_idx}] <= w_data;
            if (wr_idx == '0) begin
                be_first_q[wr_slot] <= w_strb;
            end
            // Single dword TLP must carry last BE of zero
            if (w_last) begin
                be_last_q[wr_slot] <= (wr_idx == '0) ? '0 : w_strb;
            end
        end
    end

    assign desc_valid    = (count != 2'd0);
    assign desc_addr     = addr_q[rd_slot];
    assign desc_len      = len_q[rd_slot];
    assign desc_be_first = be_first_q[rd_slot];
    assign desc_be_last  = be_last_q[rd_slot];

    assign rd_data = mem[{rd_slot, rd_index}];

endmodule

/* verilog/ob_tlp_builder.sv */
`timescale 1ns/1ps

module ob_tlp_builder import pcie_tlp_pkg::*, axi_wr_pkg::*; #(
    parameter ADDR = 32,
    parameter LEN  = 4,
    parameter FCHB = 8,
    parameter FCDB = 12
) (
    input  logic                  ob_clk,
    input  logic                  reset,

    // Descriptor from write buffer
    input  logic                  desc_valid,
    output logic                  desc_ready,
    input  logic [ADDR-1:0]       desc_addr,
    input  logic [LEN-1:0]        desc_len,
    input  logic [AXI_STRB_W-1:0] desc_be_first,
    input  logic [AXI_STRB_W-1:0] desc_be_last,
    output logic [LEN-1:0]        rd_index,
    input  logic [AXI_DATA_W-1:0] rd_data,

    // Config and credits
    input  logic                  dma_en,
    input  logic [7:0]            bus_number,
    input  logic [4:0]            dev_number,
    input  logic [2:0]            func_number,
    input  logic [FCHB-1:0]       fc_ph,
    input  logic [FCDB-1:0]       fc_pd,

    // TLP stream
    input  logic                  tx_ready,
    output logic                  tx_valid,
    output logic [AXI_DATA_W-1:0] tx_data,
    output logic                  tx_last,

    // AXI write response
    input  logic                  b_ready,
    output logic                  b_valid,
    output axi_resp_e             b_resp
);

    typedef enum logic [2:0] {
        idle,
        hdr0,
        hdr1,
        hdr2,
        data,
        resp
    } tlp_state_e;

    tlp_state_e state;

    logic [LEN+2:0]        byte_cnt;
    logic [FCDB-1:0]       need_pd;
    logic                  credit_ok;
    logic                  start;
    logic                  reject;
    logic                  tx_fire;
    logic [31:0]           addr32;
    logic [TLP_LEN_W-1:0]  dw_len;
    logic [AXI_DATA_W-1:0] hdr_w0;
    logic [AXI_DATA_W-1:0] hdr_w1;
    logic [AXI_DATA_W-1:0] hdr_w2;
    logic                  load_word;
    logic [AXI_DATA_W-1:0] word_next;

    assign byte_cnt  = {(LEN+1)'(desc_len) + 1'b1, 2'b00};
    assign need_pd   = FCDB'((int'(byte_cnt) + FC_CREDIT_BYTES - 1) / FC_CREDIT_BYTES);
    assign credit_ok = (fc_ph != '0) && (fc_pd >= need_pd);

    assign start   = (state == idle) && desc_valid && dma_en && credit_ok;
    assign reject  = (state == idle) && desc_valid && !dma_en;
    assign tx_fire = tx_valid && tx_ready;

    // Slot released once the last word leaves
    assign desc_ready = reject || (tx_fire && tx_last);

    assign dw_len = TLP_LEN_W'(desc_len) + 1'b1;
    assign addr32 = 32'(desc_addr);

    assign hdr_w0 = {1'b0, MWR32, {(24-TLP_LEN_W){1'b0}}, dw_len};
    assign hdr_w1 = {bus_number, dev_number, func_number, 8'h00, desc_be_last, desc_be_first};
    assign hdr_w2 = {addr32[31:2], 2'b00};

    // Next word onto the stream
    always_comb begin
        load_word = 1'b0;
        word_next = rd_data;
        case (state)
            idle: begin
                load_word = start;
                word_next = hdr_w0;
            end
            hdr0: begin
                load_word = tx_fire;
                word_next = hdr_w1;
            end
            hdr1: begin
                load_word = tx_fire;
                word_next = hdr_w2;
            end
            hdr2:    load_word = tx_fire;
            data:    load_word = tx_fire && !tx_last;
            default: load_word = 1'b0;
        endcase
    end

    always_ff @(posedge ob_clk) begin
        if (load_word) begin
            tx_data <= word_next;
        end
        if (reject) begin
            b_resp <= SLVERR;
        end else if (tx_fire && tx_last) begin
            b_resp <= OKAY;
        end
    end

    always_ff @(posedge ob_clk) begin
        if (reset) begin
            state    <= idle;
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
            b_valid  <= 1'b0;
            rd_index <= '0;
        end else begin
            case (state)
                idle: begin
                    rd_index <= '0;
                    if (reject) begin
                        b_valid <= 1'b1;
                        state   <= resp;
                    end else if (start) begin
                        tx_valid <= 1'b1;
                        state    <= hdr0;
                    end
                end
                hdr0: if (tx_fire) state <= hdr1;
                hdr1: if (tx_fire) state <= hdr2;
                hdr2: begin
                    if (tx_fire) begin          // First data word loaded
                        state    <= data;
                        rd_index <= rd_index + 1'b1;
                        tx_last  <= (desc_len == '0);
                    end
                end
                data: begin
                    if (tx_fire) begin
                        if (tx_last) begin
                            tx_valid <= 1'b0;
                            tx_last  <= 1'b0;
                            b_valid  <= 1'b1;
                            state    <= resp;
                        end else begin
                            rd_index <= rd_index + 1'b1;
                            tx_last  <= (rd_index == desc_len);
                        end
                    end
                end
                resp: begin
                    if (b_ready) begin
                        b_valid <= 1'b0;
                        state   <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* verilog/ob_write_bridge.sv */
`timescale 1ns/1ps

module ob_write_bridge import pcie_tlp_pkg::*, axi_wr_pkg::*; #(
    parameter ADDR = 32,        // At most 32
    parameter LEN  = 4,
    parameter FCHB = 8,
    parameter FCDB = 12
) (
    input  logic                  ob_clk,
    input  logic                  reset,

    // AXI write side
    output logic                  aw_ready,
    input  logic                  aw_valid,
    input  logic [ADDR-1:0]       aw_addr,
    input  logic [LEN-1:0]        aw_len,
    output logic                  w_ready,
    input  logic                  w_valid,
    input  logic [AXI_DATA_W-1:0] w_data,
    input  logic [AXI_STRB_W-1:0] w_strb,
    input  logic                  w_last,
    input  logic                  b_ready,
    output logic                  b_valid,
    output logic [1:0]            b_resp,

    // PCIe config and credits
    input  logic                  dma_en,
    input  logic [7:0]            bus_number,
    input  logic [4:0]            dev_number,
    input  logic [2:0]            func_number,
    output logic [2:0]            fc_sel,
    input  logic [FCHB-1:0]       fc_ph,
    input  logic [FCDB-1:0]       fc_pd,

    // TLP output
    input  logic                  tx_ready,
    output logic                  tx_valid,
    output logic [AXI_DATA_W-1:0] tx_data,
    output logic                  tx_last
);

    logic                  desc_valid;
    logic                  desc_ready;
    logic [ADDR-1:0]       desc_addr;
    logic [LEN-1:0]        desc_len;
    logic [AXI_STRB_W-1:0] desc_be_first;
    logic [AXI_STRB_W-1:0] desc_be_last;
    logic [LEN-1:0]        rd_index;
    logic [AXI_DATA_W-1:0] rd_data;

    assign fc_sel = FC_SEL_TX_AVAIL;    // Posted credits only

    ob_write_buffer #(
        .ADDR          (ADDR),
        .LEN           (LEN)
    ) u_buffer (
        .ob_clk        (ob_clk),
        .reset         (reset),
        .aw_ready      (aw_ready),
        .aw_valid      (aw_valid),
        .aw_addr       (aw_addr),
        .aw_len        (aw_len),
        .w_ready       (w_ready),
        .w_valid       (w_valid),
        .w_data        (w_data),
        .w_strb        (w_strb),
        .w_last        (w_last),
        .desc_ready    (desc_ready),
        .desc_valid    (desc_valid),
        .desc_addr     (desc_addr),
        .desc_len      (desc_len),
        .desc_be_first (desc_be_first),
        .desc_be_last  (desc_be_last),
        .rd_index      (rd_index),
        .rd_data       (rd_data)
    );

    ob_tlp_builder #(
        .ADDR          (ADDR),
        .LEN           (LEN),
        .FCHB          (FCHB),
        .FCDB          (FCDB)
    ) u_builder (
        .ob_clk        (ob_clk),
        .reset         (reset),
        .desc_valid    (desc_valid),
        .desc_ready    (desc_ready),
        .desc_addr     (desc_addr),
        .desc_len      (desc_len),
        .desc_be_first (desc_be_first),
        .desc_be_last  (desc_be_last),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .dma_en        (dma_en),
        .bus_number    (bus_number),
        .dev_number    (dev_number),
        .func_number   (func_number),
        .fc_ph         (fc_ph),
        .fc_pd         (fc_pd),
        .tx_ready      (tx_ready),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .tx_last       (tx_last),
        .b_ready       (b_ready),
        .b_valid       (b_valid),
        .b_resp        (b_resp)
    );

endmodule

/* sim/ob_clk_gen.sv */
`timescale 1ns/1ps

module ob_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic ob_clk,
    output logic reset
);

    initial begin
        ob_clk = 1'b0;
        forever #(PERIOD_NS / 2) ob_clk = ~ob_clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge ob_clk);
        reset <= 1'b0;      // Released on a rising edge
    end

endmodule

/* sim/ob_write_checker.sv */
`timescale 1ns/1ps

module ob_write_checker import pcie_tlp_pkg::*, axi_wr_pkg::*; #(
    parameter ADDR = 32,
    parameter LEN  = 4,
    parameter FCHB = 8,
    parameter FCDB = 12
) (
    input  logic                  ob_clk,
    input  logic                  reset,
    input  logic                  aw_valid,
    input  logic                  aw_ready,
    input  logic [ADDR-1:0]       aw_addr,
    input  logic [LEN-1:0]        aw_len,
    input  logic                  w_valid,
    input  logic                  w_ready,
    input  logic [AXI_DATA_W-1:0] w_data,
    input  logic [AXI_STRB_W-1:0] w_strb,
    input  logic                  w_last,
    input  logic                  b_valid,
    input  logic                  b_ready,
    input  logic [1:0]            b_resp,
    input  logic                  tx_valid,
    input  logic                  tx_ready,
    input  logic [AXI_DATA_W-1:0] tx_data,
    input  logic                  tx_last,
    input  logic                  dma_en,
    input  logic [7:0]            bus_number,
    input  logic [4:0]            dev_number,
    input  logic [2:0]            func_number,
    input  logic [2:0]            fc_sel,
    input  logic [FCHB-1:0]       fc_ph,
    input  logic [FCDB-1:0]       fc_pd,
    input  logic [8*24-1:0]       test_name,
    input  logic                  test_end,
    output int                    outstanding,
    output int                    tests_run,
    output int                    tests_failed,
    output int                    total_errors
);

    logic [31:0]           exp_words [$];
    logic                  exp_lasts [$];
    int                    exp_needs [$];   // Data credits per pending TLP
    logic [1:0]            exp_resps [$];
    logic [31:0]           beat_data [$];
    logic [31:0]           burst_addr;
    int                    burst_beats;
    logic [AXI_STRB_W-1:0] burst_be_first;
    logic                  tx_prev;
    logic [FCHB-1:0]       ph_prev;
    logic [FCDB-1:0]       pd_prev;
    int                    test_errors;
    int                    test_checks;
    int                    test_bursts;

    initial begin
        outstanding  = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        test_errors  = 0;
        test_checks  = 0;
        test_bursts  = 0;
    end

    // Expected 3DW MWr header word by index
    function automatic logic [31:0] mwr_header_word(input int idx, input logic [31:0] addr,
            input int beats, input logic [3:0] be_first, input logic [3:0] be_last,
            input logic [7:0] bus, input logic [4:0] dev, input logic [2:0] func);
        logic [3:0]  last_be;
        logic [31:0] word;
        last_be = (beats == 1) ? 4'h0 : be_last;    // Single dword carries no last BE
        case (idx)
            0:       word = {1'b0, MWR32, 14'd0, 10'(beats)};
            1:       word = {bus, dev, func, 8'h00, last_be, be_first};
            default: word = {addr[31:2], 2'b00};
        endcase
        return word;
    endfunction

    function automatic int credits_needed(input int beats);
        return (beats * 4 + FC_CREDIT_BYTES - 1) / FC_CREDIT_BYTES;
    endfunction

    task automatic report_error(input string msg);
        $display("Error in %0s: %0s", test_name, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        if (exp !== act) begin
            $display("Fail %0s: %0s expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
            total_errors++;
        end
    endtask

    // Called on the w_last beat
    task automatic record_burst();
        int i;
        if (beat_data.size() != burst_beats) begin
            report_error("W beat count differs from the AW length");
        end
        check_value("fc_sel", 32'd4, 32'(fc_sel));  // Transmit credits available
        exp_resps.push_back(dma_en ? OKAY : SLVERR);
        if (dma_en) begin
            for (i = 0; i < 3; i++) begin
                exp_words.push_back(mwr_header_word(i, burst_addr, burst_beats,
                    burst_be_first, w_strb, bus_number, dev_number, func_number));
                exp_lasts.push_back(1'b0);
            end
            for (i = 0; i < beat_data.size(); i++) begin
                exp_words.push_back(beat_data[i]);
                exp_lasts.push_back(i == beat_data.size() - 1);
            end
            exp_needs.push_back(credits_needed(burst_beats));
        end
        outstanding++;
        test_bursts++;
    endtask

    task automatic compare_word();
        logic [31:0] exp_word;
        logic        exp_last;
        if (exp_words.size() == 0) begin
            report_error("TLP word sent while no TLP was expected");
        end else begin
            exp_word = exp_words.pop_front();
            exp_last = exp_lasts.pop_front();
            check_value("tx_data", exp_word, tx_data);
            check_value("tx_last", 32'(exp_last), 32'(tx_last));
            if (exp_last && exp_needs.size() != 0) begin
                void'(exp_needs.pop_front());
            end
        end
    endtask

    task automatic compare_resp();
        if (exp_resps.size() == 0) begin
            report_error("write response returned with no burst pending");
        end else begin
            check_value("b_resp", 32'(exp_resps.pop_front()), 32'(b_resp));
            outstanding--;
        end
    endtask

    task automatic end_test_report();
        if (outstanding != 0 || exp_words.size() != 0) begin
            report_error("bursts or TLP words still pending at the end");
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("%0s: ok, %0d bursts, %0d checks", test_name, test_bursts, test_checks);
        end else begin
            tests_failed++;
            $display("%0s: %0d errors in %0d checks", test_name, test_errors, test_checks);
        end
        test_errors = 0;
        test_checks = 0;
        test_bursts = 0;
    endtask

    // Mid-cycle sample sees each transfer before its rising edge
    always @(negedge ob_clk) begin
        if (reset) begin
            tx_prev = 1'b0;
            ph_prev = '0;
            pd_prev = '0;
        end else begin
            if (aw_valid && aw_ready) begin
                burst_addr  = 32'(aw_addr);
                burst_beats = int'(aw_len) + 1;
                beat_data.delete();
            end
            if (w_valid && w_ready) begin
                if (beat_data.size() == 0) begin
                    burst_be_first = w_strb;
                end
                beat_data.push_back(w_data);
                if (w_last) begin
                    record_burst();
                end
            end
            // Start of a TLP needs credits in the cycle before
            if (tx_valid && !tx_prev && exp_needs.size() != 0) begin
                if (ph_prev == '0 || pd_prev < exp_needs[0]) begin
                    report_error("TLP started before enough posted credits were available");
                end
            end
            if (tx_valid && tx_ready) begin
                compare_word();
            end
            if (b_valid && b_ready) begin
                compare_resp();
            end
            if (test_end) begin
                end_test_report();
            end
            tx_prev = tx_valid;
            ph_prev = fc_ph;
            pd_prev = fc_pd;
        end
    end

endmodule

/* sim/ob_write_assert.sv */
`timescale 1ns/1ps

module ob_write_assert import axi_wr_pkg::*; (
    input logic                  ob_clk,
    input logic                  reset,
    input logic                  aw_ready,
    input logic                  tx_valid,
    input logic                  tx_ready,
    input logic [AXI_DATA_W-1:0] tx_data,
    input logic                  tx_last,
    input logic                  b_valid,
    input logic                  b_ready,
    input logic [1:0]            b_resp
);

    int assert_fails;

    initial assert_fails = 0;

    tx_hold: assert property (@(posedge ob_clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
    else begin
        assert_fails++;
        $error("tx_valid dropped or the TLP word changed before tx_ready");
    end

    b_hold: assert property (@(posedge ob_clk) disable iff (reset)
        b_valid && !b_ready |=> b_valid && $stable(b_resp))
    else begin
        assert_fails++;
        $error("b_valid dropped or b_resp changed before b_ready");
    end

    // Framing marker only inside a valid word
    last_in_valid: assert property (@(posedge ob_clk) disable iff (reset)
        tx_last |-> tx_valid)
    else begin
        assert_fails++;
        $error("tx_last high while tx_valid is low");
    end

    aw_after_reset: assert property (@(posedge ob_clk) $fell(reset) |-> !aw_ready)
    else begin
        assert_fails++;
        $error("aw_ready high in the first cycle after reset");
    end

endmodule

/* sim/tb_ob_write.sv */
`timescale 1ns/1ps

module tb_ob_write import axi_wr_pkg::*; ();

    localparam ADDR = 32;
    localparam LEN  = 4;
    localparam FCHB = 8;
    localparam FCDB = 12;

    localparam logic [31:0] SEED = 32'h85888a99;
    localparam int N_BURSTS       = 40;
    localparam int CYC_PER_BURST  = 40;
    localparam int SLACK_CYCLES   = 1400;   // Credit stall, reset and drain
    localparam int TIMEOUT_CYCLES = N_BURSTS * CYC_PER_BURST + SLACK_CYCLES;

    localparam logic [FCHB-1:0] DEF_PH = 8'h20;
    localparam logic [FCDB-1:0] DEF_PD = 12'h100;

    logic                  ob_clk;
    logic                  reset;
    logic                  aw_valid, aw_ready;
    logic [ADDR-1:0]       aw_addr;
    logic [LEN-1:0]        aw_len;
    logic                  w_valid, w_ready, w_last;
    logic [AXI_DATA_W-1:0] w_data;
    logic [AXI_STRB_W-1:0] w_strb;
    logic                  b_valid, b_ready;
    logic [1:0]            b_resp;
    logic                  dma_en;
    logic [7:0]            bus_number;
    logic [4:0]            dev_number;
    logic [2:0]            func_number;
    logic [2:0]            fc_sel;
    logic [FCHB-1:0]       fc_ph;
    logic [FCDB-1:0]       fc_pd;
    logic                  tx_valid, tx_ready, tx_last;
    logic [AXI_DATA_W-1:0] tx_data;

    logic [8*24-1:0] test_name;
    logic            test_end;
    logic            rand_ready;
    int              outstanding, tests_run, tests_failed, total_errors;
    int              cycle_cnt;

    ob_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clk_gen (
        .ob_clk (ob_clk),
        .reset  (reset)
    );

    ob_write_bridge #(.ADDR(ADDR), .LEN(LEN), .FCHB(FCHB), .FCDB(FCDB)) DUT (
        .ob_clk(ob_clk), .reset(reset),
        .aw_ready(aw_ready), .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_len(aw_len),
        .w_ready(w_ready), .w_valid(w_valid), .w_data(w_data), .w_strb(w_strb),
        .w_last(w_last), .b_ready(b_ready), .b_valid(b_valid), .b_resp(b_resp),
        .dma_en(dma_en), .bus_number(bus_number), .dev_number(dev_number),
        .func_number(func_number), .fc_sel(fc_sel), .fc_ph(fc_ph), .fc_pd(fc_pd),
        .tx_ready(tx_ready), .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last)
    );

    ob_write_checker #(.ADDR(ADDR), .LEN(LEN), .FCHB(FCHB), .FCDB(FCDB)) u_checker (
        .ob_clk(ob_clk), .reset(reset),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr), .aw_len(aw_len),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
        .w_last(w_last), .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_last(tx_last),
        .dma_en(dma_en), .bus_number(bus_number), .dev_number(dev_number),
        .func_number(func_number), .fc_sel(fc_sel), .fc_ph(fc_ph), .fc_pd(fc_pd),
        .test_name(test_name), .test_end(test_end), .outstanding(outstanding),
        .tests_run(tests_run), .tests_failed(tests_failed), .total_errors(total_errors)
    );

    bind ob_write_bridge ob_write_assert u_assert (
        .ob_clk(ob_clk), .reset(reset), .aw_ready(aw_ready),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_last(tx_last),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp)
    );

    // Sink side readiness
    always @(posedge ob_clk) begin
        if (rand_ready) begin
            tx_ready <= ($urandom_range(0, 3) != 0);
            b_ready  <= ($urandom_range(0, 1) != 0);
        end else begin
            tx_ready <= 1'b1;
            b_ready  <= 1'b1;
        end
    end

    task automatic send_burst(input logic [31:0] addr, input int beats, input bit gaps);
        int i;
        aw_valid <= 1'b1;
        aw_addr  <= addr;
        aw_len   <= LEN'(beats - 1);
        @(posedge ob_clk);
        while (!aw_ready) @(posedge ob_clk);
        aw_valid <= 1'b0;
        for (i = 0; i < beats; i++) begin
            if (gaps && $urandom_range(0, 3) == 0) begin
                w_valid <= 1'b0;
                @(posedge ob_clk);
            end
            w_valid <= 1'b1;
            w_data  <= $urandom;
            w_strb  <= AXI_STRB_W'($urandom_range(1, 15));
            w_last  <= (i == beats - 1);
            @(posedge ob_clk);
            while (!w_ready) @(posedge ob_clk);
        end
        w_valid <= 1'b0;
        w_last  <= 1'b0;
    endtask

    // Drain, then let the checker close the test
    task automatic finish_test();
        while (outstanding != 0) @(posedge ob_clk);
        test_end <= 1'b1;
        @(posedge ob_clk);
        test_end <= 1'b0;
        @(posedge ob_clk);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge ob_clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        int i;
        int seed_ret;
        seed_ret    = $urandom(SEED);
        aw_valid    <= 1'b0;
        aw_addr     <= '0;
        aw_len      <= '0;
        w_valid     <= 1'b0;
        w_data      <= '0;
        w_strb      <= '0;
        w_last      <= 1'b0;
        b_ready     <= 1'b1;
        tx_ready    <= 1'b1;
        dma_en      <= 1'b1;
        bus_number  <= 8'h3a;
        dev_number  <= 5'h15;
        func_number <= 3'h5;
        fc_ph       <= DEF_PH;
        fc_pd       <= DEF_PD;
        rand_ready  <= 1'b0;
        test_end    <= 1'b0;
        test_name   <= "reset";

        @(posedge ob_clk);
        while (reset) @(posedge ob_clk);

        test_name <= "single_beat";
        send_burst($urandom, 1, 1'b0);
        finish_test();

        test_name <= "random_bursts";
        for (i = 0; i < 16; i++) begin
            send_burst($urandom, $urandom_range(1, 16), 1'b1);
        end
        finish_test();

        test_name  <= "random_ready";
        rand_ready <= 1'b1;
        for (i = 0; i < 16; i++) begin
            send_burst($urandom, $urandom_range(1, 16), 1'b1);
        end
        finish_test();
        rand_ready <= 1'b0;

        // 8 dwords need two data credits
        test_name <= "credit_stall";
        fc_pd     <= FCDB'(1);
        send_burst($urandom, 8, 1'b0);
        repeat (50) @(posedge ob_clk);
        fc_pd <= FCDB'(2);
        finish_test();
        fc_pd <= DEF_PD;

        test_name <= "dma_disabled";
        dma_en    <= 1'b0;
        for (i = 0; i < 6; i++) begin
            send_burst($urandom, $urandom_range(1, 16), 1'b0);
        end
        finish_test();
        dma_en <= 1'b1;

        $display("Summary: %0d tests run, %0d failing, %0d check errors, %0d assertion failures",
            tests_run, tests_failed, total_errors, DUT.u_assert.assert_fails);
        if (tests_failed == 0 && total_errors == 0 && DUT.u_assert.assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/pcie_tlp_pkg.sv
verilog/axi_wr_pkg.sv
verilog/ob_write_buffer.sv
verilog/ob_tlp_builder.sv
verilog/ob_write_bridge.sv
sim/ob_clk_gen.sv
sim/ob_write_checker.sv
sim/ob_write_assert.sv
sim/tb_ob_write.sv

/* Bender.yml */
package:
  name: ob_write_bridge

sources:
  # Design
  - files:
      - verilog/pcie_tlp_pkg.sv
      - verilog/axi_wr_pkg.sv
      - verilog/ob_write_buffer.sv
      - verilog/ob_tlp_builder.sv
      - verilog/ob_write_bridge.sv
  # Testbench
  - target: simulation
    files:
      - sim/ob_clk_gen.sv
      - sim/ob_write_checker.sv
      - sim/ob_write_assert.sv
      - sim/tb_ob_write.sv
